/* dv/exu_checker.sv */
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_checker (
  input                      clk,
  input                      rst,
  input                      in_valid_i,
  input                      in_ready_o,
  input  exu_pkg::word_t     pc_i,
  input  exu_pkg::word_t     op1_i,
  input  exu_pkg::word_t     op2_i,
  input  exu_pkg::word_t     opj_i,
  input  exu_pkg::word_t     imm_i,
  input  exu_pkg::alu_op_t   alu_op_i,
  input  exu_pkg::func3_t    func3_i,
  input  exu_pkg::reg_idx_t  rd_i,
  input                      ren_i,
  input                      wen_i,
  input                      jen_i,
  input                      ben_i,
  input                      system_i,
  input                      csr_wen_i,
  input                      ecall_i,
  input                      mret_i,
  input                      out_valid_o,
  input                      out_ready_i,
  input  exu_pkg::reg_idx_t  rd_o,
  input  exu_pkg::word_t     reg_wdata_o,
  input  exu_pkg::word_t     npc_o,
  input                      redirect_o,
  input                      mem_req
);

  import exu_pkg::*;

  word_t    ref_mem [`EXU_DMEM_WORDS];
  word_t    m_status, m_tvec, m_epc, m_cause;
  word_t    q_pc, q_op1, q_op2, q_opj, q_imm;
  alu_op_t  q_op;
  func3_t   q_f3;
  reg_idx_t q_rd;
  logic     q_ren, q_wen, q_jen, q_ben, q_sys, q_csrw, q_ecall, q_mret;
  word_t    addr, alu_exp, csr_old, csr_new, exp_wdata, exp_npc;
  logic     exp_redirect, accept, commit;
  int       fail_cnt = 0;

  function automatic word_t alu_model(alu_op_t op, word_t a, word_t b);
    case (op)
      `EXU_ALU_ADD:  return a + b;
      `EXU_ALU_SUB:  return a - b;
      `EXU_ALU_XOR:  return a ^ b;
      `EXU_ALU_OR:   return a | b;
      `EXU_ALU_AND:  return a & b;
      `EXU_ALU_SLL:  return a << b[4:0];
      `EXU_ALU_SRL:  return a >> b[4:0];
      `EXU_ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      `EXU_ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      `EXU_ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default:       return '0;
    endcase
  endfunction

  initial begin
    for (int i = 0; i < `EXU_DMEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
  end

  assign accept = in_valid_i & in_ready_o;
  assign commit = out_valid_o & out_ready_i;
  assign addr = q_opj + q_imm;
  assign alu_exp = alu_model(q_op, q_op1, q_op2);

  always_comb begin
    case (q_imm[11:0])
      `EXU_CSR_MSTATUS: csr_old = m_status;
      `EXU_CSR_MTVEC:   csr_old = m_tvec;
      `EXU_CSR_MEPC:    csr_old = m_epc;
      `EXU_CSR_MCAUSE:  csr_old = m_cause;
      default:          csr_old = '0;
    endcase
    case (q_f3)
      `EXU_F3_CSRRS, `EXU_F3_CSRRSI: csr_new = csr_old | q_op1;
      `EXU_F3_CSRRC, `EXU_F3_CSRRCI: csr_new = csr_old & ~q_op1;
      default:                       csr_new = q_op1;
    endcase
    if (q_rd == 0) exp_wdata = '0;
    else if (q_ren) exp_wdata = ref_mem[addr[7:2]];
    else if (q_sys) exp_wdata = csr_old;
    else exp_wdata = alu_exp;
    if (q_ben) begin
      exp_redirect = (q_op == `EXU_ALU_SUB) ? (alu_exp == 0) :
                     (q_op == `EXU_ALU_XOR || q_op == `EXU_ALU_SLT ||
                      q_op == `EXU_ALU_SLTU) ? (alu_exp != 0) : 1'b0;
    end else begin
      exp_redirect = q_jen | q_ecall | q_mret;
    end
    exp_npc = q_ecall ? m_tvec : (q_mret ? m_epc : addr);
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      q_pc <= pc_i;
      q_op1 <= op1_i;
      q_op2 <= op2_i;
      q_opj <= opj_i;
      q_imm <= imm_i;
      q_op <= alu_op_i;
      q_f3 <= func3_i;
      q_rd <= rd_i;
      {q_ren, q_wen, q_jen, q_ben} <= {ren_i, wen_i, jen_i, ben_i};
      {q_sys, q_csrw, q_ecall, q_mret} <= {system_i, csr_wen_i, ecall_i, mret_i};
    end
  end

  // Reference state moves only when a result is consumed
  always_ff @(posedge clk) begin
    if (rst) begin
      {m_status, m_tvec, m_epc, m_cause} <= '0;
    end else if (commit) begin
      if (q_wen) ref_mem[addr[7:2]] <= q_op2;
      if (q_ecall) begin
        m_epc <= q_pc;
        m_cause <= 32'd11;
        m_status[7] <= m_status[3];
        m_status[3] <= 1'b0;
      end else if (q_mret) begin
        m_status[3] <= m_status[7];
        m_status[7] <= 1'b1;
      end else if (q_csrw) begin
        case (q_imm[11:0])
          `EXU_CSR_MSTATUS: m_status <= csr_new;
          `EXU_CSR_MTVEC:   m_tvec <= csr_new;
          `EXU_CSR_MEPC:    m_epc <= csr_new;
          `EXU_CSR_MCAUSE:  m_cause <= csr_new;
          default: ;
        endcase
      end
    end
  end

  a_wdata: assert property (@(posedge clk) disable iff (rst)
    out_valid_o |-> reg_wdata_o == exp_wdata)
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: reg_wdata_o got %h expected %h", $time,
             $sampled(reg_wdata_o), $sampled(exp_wdata));
    end

  a_rd: assert property (@(posedge clk) disable iff (rst)
    out_valid_o |-> rd_o == q_rd)
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: rd_o got %h expected %h", $time,
             $sampled(rd_o), $sampled(q_rd));
    end

  a_redirect: assert property (@(posedge clk) disable iff (rst)
    out_valid_o |-> redirect_o == exp_redirect)
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: redirect_o got %b expected %b", $time,
             $sampled(redirect_o), $sampled(exp_redirect));
    end

  a_npc: assert property (@(posedge clk) disable iff (rst)
    out_valid_o |-> npc_o == exp_npc)
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: npc_o got %h expected %h", $time,
             $sampled(npc_o), $sampled(exp_npc));
    end

  a_alu_latency: assert property (@(posedge clk) disable iff (rst)
    accept && !(ren_i || wen_i) |=> out_valid_o)
    else begin
      fail_cnt++;
      $error("out_valid_o did not rise one edge after accept at %0t", $time);
    end

  a_mem_latency: assert property (@(posedge clk) disable iff (rst)
    accept && (ren_i || wen_i) |=> (mem_req && !out_valid_o) ##1 !out_valid_o ##1 out_valid_o)
    else begin
      fail_cnt++;
      $error("Load or store timing wrong near %0t", $time);
    end

  a_stall: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |-> !in_ready_o ##1
      (out_valid_o && $stable(reg_wdata_o) && $stable(npc_o) && $stable(redirect_o)))
    else begin
      fail_cnt++;
      $error("Result or ready not held under back-pressure at %0t", $time);
    end

  a_reset: assert property (@(posedge clk) rst |=> !out_valid_o && in_ready_o)
    else begin
      fail_cnt++;
      $error("Wrong handshake state after reset at %0t", $time);
    end

endmodule

bind exu_top exu_checker u_checker (.*);

/* dv/exu_tb.sv */
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_tb;

  import exu_pkg::*;

  localparam int N_INSTR = 40 + 16 + 16 + 8;

  logic clk, rst, in_valid_i, in_ready_o, out_valid_o, out_ready_i, redirect_o;
  logic ren_i, wen_i, jen_i, ben_i, system_i, csr_wen_i, ecall_i, mret_i;
  word_t pc_i, op1_i, op2_i, opj_i, imm_i, reg_wdata_o, npc_o;
  alu_op_t alu_op_i;
  func3_t func3_i;
  reg_idx_t rd_i, rd_o;
  logic [31:0] rng = 32'd3552;
  logic [31:0] stall_rng = 32'd3552;
  word_t addr;
  word_t operand;

  exu_top u_exu_top (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  task automatic set_defaults();
    pc_i <= {next_rand() & 32'hfffc};
    op1_i <= next_rand();
    op2_i <= next_rand();
    opj_i <= '0;
    imm_i <= '0;
    alu_op_i <= `EXU_ALU_ADD;
    func3_i <= '0;
    rd_i <= reg_idx_t'(next_rand());
    {ren_i, wen_i, jen_i, ben_i} <= '0;
    {system_i, csr_wen_i, ecall_i, mret_i} <= '0;
  endtask

  // Holds valid until the stage takes the instruction
  task automatic send_instr();
    in_valid_i <= 1'b1;
    do @(posedge clk); while (!in_ready_o);
    in_valid_i <= 1'b0;
  endtask

  task automatic csr_op(input logic [11:0] csr, input func3_t f3, input word_t v);
    set_defaults();
    imm_i <= {20'd0, csr};
    func3_i <= f3;
    op1_i <= v;
    system_i <= 1'b1;
    csr_wen_i <= 1'b1;
    rd_i <= 5'd7;
    send_instr();
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Random stalls on the result side
  always @(posedge clk) begin
    stall_rng = xorshift(stall_rng);
    out_ready_i <= (stall_rng % 4) != 0;
  end

  always @(posedge clk) begin
    if (u_exu_top.u_checker.fail_cnt != 0) begin
      $display("TB FAILED");
      $fatal(1, "assertion failure reported by the checker");
    end
  end

  initial begin
    repeat (16 + 200 * N_INSTR) @(posedge clk);
    $display("TB FAILED");
    $fatal(1, "watchdog expired before the tests finished");
  end

  initial begin
    rst = 1'b1;
    in_valid_i = 1'b0;
    out_ready_i = 1'b0;
    {pc_i, op1_i, op2_i, opj_i, imm_i} = '0;
    alu_op_i = '0;
    func3_i = '0;
    rd_i = '0;
    {ren_i, wen_i, jen_i, ben_i, system_i, csr_wen_i, ecall_i, mret_i} = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < 40; i++) begin
      set_defaults();
      alu_op_i <= alu_op_t'(i % 10);
      send_instr();
    end
    for (int i = 0; i < 16; i++) begin
      set_defaults();
      ben_i <= (i % 5) != 4;
      jen_i <= (i % 5) == 4;
      case (i % 5)
        0: alu_op_i <= `EXU_ALU_SUB;
        1: alu_op_i <= `EXU_ALU_XOR;
        2: alu_op_i <= `EXU_ALU_SLT;
        3: alu_op_i <= `EXU_ALU_SLTU;
        default: alu_op_i <= `EXU_ALU_ADD;
      endcase
      // Equal operands now and then so both branch outcomes occur
      if (i % 10 < 2) begin
        operand = next_rand();
        op1_i <= operand;
        op2_i <= operand;
      end
      opj_i <= next_rand();
      imm_i <= next_rand() & 32'hfff;
      send_instr();
    end
    for (int i = 0; i < 8; i++) begin
      addr = next_rand() & 32'hfc;
      set_defaults();
      wen_i <= 1'b1;
      opj_i <= addr;
      send_instr();
      set_defaults();
      ren_i <= 1'b1;
      opj_i <= addr;
      rd_i <= 5'd3;
      send_instr();
    end
    csr_op(`EXU_CSR_MTVEC, `EXU_F3_CSRRW, 32'h0000_0100);
    csr_op(`EXU_CSR_MSTATUS, `EXU_F3_CSRRS, 32'h0000_0088);
    csr_op(`EXU_CSR_MSTATUS, `EXU_F3_CSRRC, 32'h0000_0080);
    csr_op(`EXU_CSR_MCAUSE, `EXU_F3_CSRRWI, 32'h0000_0005);
    set_defaults();
    ecall_i <= 1'b1;
    rd_i <= '0;
    send_instr();
    csr_op(`EXU_CSR_MEPC, `EXU_F3_CSRRS, 32'h0);
    set_defaults();
    mret_i <= 1'b1;
    rd_i <= '0;
    send_instr();
    csr_op(`EXU_CSR_MSTATUS, `EXU_F3_CSRRS, 32'h0);
    do @(posedge clk); while (out_valid_o);
    repeat (4) @(posedge clk);
    if (u_exu_top.u_checker.fail_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("TB FAILED");
      $fatal(1, "checker reported failures");
    end
  end

endmodule

/* list.f */
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_alu.sv
rtl/exu_csr.sv
rtl/exu_branch.sv
rtl/exu_core.sv
rtl/exu_dmem.sv
rtl/exu_top.sv
dv/exu_checker.sv
dv/exu_tb.sv

/* rtl/exu_alu.sv */
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_alu (
  input  exu_pkg::word_t   a_i,
  input  exu_pkg::word_t   b_i,
  input  exu_pkg::alu_op_t op_i,
  output exu_pkg::word_t   res_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      `EXU_ALU_ADD:  res_o = a_i + b_i;
      `EXU_ALU_SUB:  res_o = a_i - b_i;
      `EXU_ALU_XOR:  res_o = a_i ^ b_i;
      `EXU_ALU_OR:   res_o = a_i | b_i;
      `EXU_ALU_AND:  res_o = a_i & b_i;
      `EXU_ALU_SLL:  res_o = a_i << shamt;
      `EXU_ALU_SRL:  res_o = a_i >> shamt;
      `EXU_ALU_SRA:  res_o = $signed(a_i) >>> shamt;
      `EXU_ALU_SLT: begin
        res_o = {{(`EXU_XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      end
      `EXU_ALU_SLTU: begin
        res_o = {{(`EXU_XLEN-1){1'b0}}, a_i < b_i};
      end
      default:       res_o = '0;
    endcase
  end

endmodule

/* rtl/exu_branch.sv */
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_branch (
  input                      ben_i,
  input                      jen_i,
  input                      ecall_i,
  input                      mret_i,
  input  exu_pkg::alu_op_t   alu_op_i,
  input  exu_pkg::word_t     alu_res_i,
  input  exu_pkg::word_t     target_i,
  input  exu_pkg::word_t     mtvec_i,
  input  exu_pkg::word_t     mepc_i,
  input  exu_pkg::word_t     csr_rdata_i,
  input  exu_pkg::word_t     src1_i,
  input  exu_pkg::func3_t    func3_i,
  output logic               redirect_o,
  output exu_pkg::word_t     npc_o,
  output exu_pkg::word_t     csr_wdata_o
);

  always_comb begin
    if (ben_i) begin
      case (alu_op_i)
        // Equal test under SUB
        `EXU_ALU_SUB:  redirect_o = ~|alu_res_i;
        `EXU_ALU_XOR,
        `EXU_ALU_SLT,
        `EXU_ALU_SLTU: redirect_o = |alu_res_i;
        default:       redirect_o = 1'b0;
      endcase
    end else begin
      redirect_o = jen_i | ecall_i | mret_i;
    end
  end

  assign npc_o = ecall_i ? mtvec_i : (mret_i ? mepc_i : target_i);

  always_comb begin
    case (func3_i)
      `EXU_F3_CSRRW, `EXU_F3_CSRRWI: csr_wdata_o = src1_i;
      `EXU_F3_CSRRS, `EXU_F3_CSRRSI: csr_wdata_o = csr_rdata_i | src1_i;
      `EXU_F3_CSRRC, `EXU_F3_CSRRCI: csr_wdata_o = csr_rdata_i & ~src1_i;
      default:                       csr_wdata_o = '0;
    endcase
  end

endmodule

/* rtl/exu_core.sv */
`timescale 1ns/1ps

module exu_core (
  input                        clk,
  input                        rst,
  input                        in_valid_i,
  output logic                 in_ready_o,
  input  exu_pkg::word_t       pc_i,
  input  exu_pkg::word_t       op1_i,
  input  exu_pkg::word_t       op2_i,
  input  exu_pkg::word_t       opj_i,
  input  exu_pkg::word_t       imm_i,
  input  exu_pkg::alu_op_t     alu_op_i,
  input  exu_pkg::func3_t      func3_i,
  input  exu_pkg::reg_idx_t    rd_i,
  input                        ren_i,
  input                        wen_i,
  input                        jen_i,
  input                        ben_i,
  input                        system_i,
  input                        csr_wen_i,
  input                        ecall_i,
  input                        mret_i,
  output logic                 out_valid_o,
  input                        out_ready_i,
  output exu_pkg::reg_idx_t    rd_o,
  output exu_pkg::word_t       reg_wdata_o,
  output exu_pkg::word_t       npc_o,
  output logic                 redirect_o,
  input  exu_pkg::word_t       alu_res_i,
  input  exu_pkg::word_t       csr_rdata_i,
  input  exu_pkg::word_t       branch_npc_i,
  input                        branch_redirect_i,
  output exu_pkg::word_t       src1_o,
  output exu_pkg::word_t       src2_o,
  output exu_pkg::word_t       pc_o,
  output exu_pkg::word_t       target_o,
  output exu_pkg::alu_op_t     alu_op_o,
  output exu_pkg::func3_t      func3_o,
  output logic                 ben_o,
  output logic                 jen_o,
  output logic                 ecall_o,
  output logic                 mret_o,
  output logic                 csr_wen_o,
  output exu_pkg::csr_addr_t   csr_addr_o,
  output logic                 commit_o,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output exu_pkg::word_t       mem_addr_o,
  output exu_pkg::word_t       mem_wdata_o,
  input                        mem_ack_i,
  input  exu_pkg::word_t       mem_rdata_i
);

  import exu_pkg::*;

  lsu_state_t lsu_state;
  word_t      opj_q;
  word_t      imm_q;
  word_t      load_q;
  logic       ren_q;
  logic       wen_q;
  logic       system_q;
  logic       accept;

  assign accept     = in_valid_i & in_ready_o;
  assign commit_o   = out_valid_o & out_ready_i;
  assign in_ready_o = (~out_valid_o | out_ready_i) & (lsu_state != LSU_REQ);

  // Issue register
  always_ff @(posedge clk) begin
    if (accept) begin
      pc_o      <= pc_i;
      src1_o    <= op1_i;
      src2_o    <= op2_i;
      opj_q     <= opj_i;
      imm_q     <= imm_i;
      alu_op_o  <= alu_op_i;
      func3_o   <= func3_i;
      rd_o      <= rd_i;
      ren_q     <= ren_i;
      wen_q     <= wen_i;
      jen_o     <= jen_i;
      ben_o     <= ben_i;
      system_q  <= system_i;
      csr_wen_o <= csr_wen_i;
      ecall_o   <= ecall_i;
      mret_o    <= mret_i;
    end
  end

  // Accept may follow a commit on the same edge and overrides it
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o <= 1'b0;
      lsu_state   <= LSU_IDLE;
    end else begin
      if (commit_o) begin
        out_valid_o <= 1'b0;
        lsu_state   <= LSU_IDLE;
      end
      if (lsu_state == LSU_REQ && mem_ack_i) begin
        out_valid_o <= 1'b1;
        lsu_state   <= LSU_DONE;
      end
      if (accept) begin
        if (ren_i || wen_i) begin
          lsu_state <= LSU_REQ;
        end else begin
          out_valid_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_state == LSU_REQ && mem_ack_i) begin
      load_q <= mem_rdata_i;
    end
  end

  assign target_o    = opj_q + imm_q;
  assign csr_addr_o  = imm_q[11:0];
  assign mem_req_o   = (lsu_state == LSU_REQ);
  assign mem_we_o    = wen_q;
  assign mem_addr_o  = target_o;
  assign mem_wdata_o = src2_o;

  always_comb begin
    if (rd_o == '0) begin
      reg_wdata_o = '0;
    end else if (ren_q) begin
      reg_wdata_o = load_q;
    end else if (system_q) begin
      reg_wdata_o = csr_rdata_i;
    end else begin
      reg_wdata_o = alu_res_i;
    end
  end

  assign npc_o      = branch_npc_i;
  assign redirect_o = branch_redirect_i;

endmodule

/* rtl/exu_csr.sv */
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_csr (
  input                       clk,
  input                       rst,
  input  exu_pkg::csr_addr_t  addr_i,
  input                       wen_i,
  input  exu_pkg::word_t      wdata_i,
  input                       trap_i,
  input                       mret_i,
  input  exu_pkg::word_t      pc_i,
  input                       commit_i,
  output exu_pkg::word_t      rdata_o,
  output exu_pkg::word_t      mtvec_o,
  output exu_pkg::word_t      mepc_o
);

  import exu_pkg::*;

  word_t mstatus;
  word_t mtvec;
  word_t mepc;
  word_t mcause;

  always_comb begin
    case (addr_i)
      `EXU_CSR_MSTATUS: rdata_o = mstatus;
      `EXU_CSR_MTVEC:   rdata_o = mtvec;
      `EXU_CSR_MEPC:    rdata_o = mepc;
      `EXU_CSR_MCAUSE:  rdata_o = mcause;
      default:          rdata_o = '0;
    endcase
  end

  // Updates land only when the instruction leaves the stage
  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (commit_i) begin
      if (trap_i) begin
        mepc   <= pc_i;
        mcause <= `EXU_CAUSE_ECALL_M;
        mstatus[`EXU_MSTATUS_MPIE] <= mstatus[`EXU_MSTATUS_MIE];
        mstatus[`EXU_MSTATUS_MIE]  <= 1'b0;
      end else if (mret_i) begin
        mstatus[`EXU_MSTATUS_MIE]  <= mstatus[`EXU_MSTATUS_MPIE];
        mstatus[`EXU_MSTATUS_MPIE] <= 1'b1;
      end else if (wen_i) begin
        case (addr_i)
          `EXU_CSR_MSTATUS: mstatus <= wdata_i;
          `EXU_CSR_MTVEC:   mtvec   <= wdata_i;
          `EXU_CSR_MEPC:    mepc    <= wdata_i;
          `EXU_CSR_MCAUSE:  mcause  <= wdata_i;
          default:          ;
        endcase
      end
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

endmodule

/* rtl/exu_dmem.sv */
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_dmem (
  input                    clk,
  input                    rst,
  input                    req_i,
  input                    we_i,
  input  exu_pkg::word_t   addr_i,
  input  exu_pkg::word_t   wdata_i,
  output logic             ack_o,
  output exu_pkg::word_t   rdata_o
);

  import exu_pkg::*;

  localparam int unsigned AW = $clog2(`EXU_DMEM_WORDS);

  word_t          mem [`EXU_DMEM_WORDS];
  logic [AW-1:0]  idx;
  logic           start;

  initial begin
    for (int i = 0; i < `EXU_DMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  assign idx = addr_i[AW+1:2];

  // No new access while the previous ack is still out
  assign start = req_i & ~ack_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      if (we_i) begin
        mem[idx] <= wdata_i;
      end
      rdata_o <= mem[idx];
    end
  end

endmodule

/* rtl/exu_pkg.sv */
`include "exu_settings.svh"

package exu_pkg;

  // Data and address value
  typedef logic [`EXU_XLEN-1:0] word_t;

  typedef logic [3:0] alu_op_t;

  typedef logic [11:0] csr_addr_t;

  // Destination register index
  typedef logic [4:0] reg_idx_t;

  typedef logic [2:0] func3_t;

  // Load/store sequencer
  typedef enum logic [1:0] {
    LSU_IDLE,
    LSU_REQ,
    LSU_DONE
  } lsu_state_t;

endpackage

/* rtl/exu_settings.svh */
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

`define EXU_XLEN 32

// ALU op codes
`define EXU_ALU_ADD  4'd0
`define EXU_ALU_SUB  4'd1
`define EXU_ALU_XOR  4'd2
`define EXU_ALU_OR   4'd3
`define EXU_ALU_AND  4'd4
`define EXU_ALU_SLL  4'd5
`define EXU_ALU_SRL  4'd6
`define EXU_ALU_SRA  4'd7
`define EXU_ALU_SLT  4'd8
`define EXU_ALU_SLTU 4'd9

// CSR func3 codes
`define EXU_F3_CSRRW  3'b001
`define EXU_F3_CSRRS  3'b010
`define EXU_F3_CSRRC  3'b011
`define EXU_F3_CSRRWI 3'b101
`define EXU_F3_CSRRSI 3'b110
`define EXU_F3_CSRRCI 3'b111

// Machine CSR addresses
`define EXU_CSR_MSTATUS 12'h300
`define EXU_CSR_MTVEC   12'h305
`define EXU_CSR_MEPC    12'h341
`define EXU_CSR_MCAUSE  12'h342

// mstatus bit positions and the ecall cause
`define EXU_MSTATUS_MIE  3
`define EXU_MSTATUS_MPIE 7
`define EXU_CAUSE_ECALL_M 32'd11

`define EXU_DMEM_WORDS 64

`endif

/* rtl/exu_top.sv */
`timescale 1ns/1ps

module exu_top (
  input                        clk,
  input                        rst,
  input                        in_valid_i,
  output logic                 in_ready_o,
  input  exu_pkg::word_t       pc_i,
  input  exu_pkg::word_t       op1_i,
  input  exu_pkg::word_t       op2_i,
  input  exu_pkg::word_t       opj_i,
  input  exu_pkg::word_t       imm_i,
  input  exu_pkg::alu_op_t     alu_op_i,
  input  exu_pkg::func3_t      func3_i,
  input  exu_pkg::reg_idx_t    rd_i,
  input                        ren_i,
  input                        wen_i,
  input                        jen_i,
  input                        ben_i,
  input                        system_i,
  input                        csr_wen_i,
  input                        ecall_i,
  input                        mret_i,
  output logic                 out_valid_o,
  input                        out_ready_i,
  output exu_pkg::reg_idx_t    rd_o,
  output exu_pkg::word_t       reg_wdata_o,
  output exu_pkg::word_t       npc_o,
  output logic                 redirect_o
);

  import exu_pkg::*;

  word_t     src1, src2, pc, target, alu_res;
  word_t     csr_rdata, csr_wdata, mtvec, mepc;
  word_t     branch_npc;
  word_t     mem_addr, mem_wdata, mem_rdata;
  alu_op_t   alu_op;
  func3_t    func3;
  csr_addr_t csr_addr;
  logic      ben, jen, ecall, mret, csr_wen, commit;
  logic      branch_redirect;
  logic      mem_req, mem_we, mem_ack;

  exu_core u_core (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
    .pc_i(pc_i), .op1_i(op1_i), .op2_i(op2_i), .opj_i(opj_i), .imm_i(imm_i),
    .alu_op_i(alu_op_i), .func3_i(func3_i), .rd_i(rd_i),
    .ren_i(ren_i), .wen_i(wen_i), .jen_i(jen_i), .ben_i(ben_i),
    .system_i(system_i), .csr_wen_i(csr_wen_i), .ecall_i(ecall_i), .mret_i(mret_i),
    .out_valid_o(out_valid_o), .out_ready_i(out_ready_i),
    .rd_o(rd_o), .reg_wdata_o(reg_wdata_o), .npc_o(npc_o), .redirect_o(redirect_o),
    .alu_res_i(alu_res), .csr_rdata_i(csr_rdata),
    .branch_npc_i(branch_npc), .branch_redirect_i(branch_redirect),
    .src1_o(src1), .src2_o(src2), .pc_o(pc), .target_o(target),
    .alu_op_o(alu_op), .func3_o(func3),
    .ben_o(ben), .jen_o(jen), .ecall_o(ecall), .mret_o(mret), .csr_wen_o(csr_wen),
    .csr_addr_o(csr_addr), .commit_o(commit),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata)
  );

  exu_alu u_alu (
    .a_i(src1), .b_i(src2), .op_i(alu_op), .res_o(alu_res)
  );

  exu_csr u_csr (
    .clk(clk), .rst(rst),
    .addr_i(csr_addr), .wen_i(csr_wen), .wdata_i(csr_wdata),
    .trap_i(ecall), .mret_i(mret), .pc_i(pc), .commit_i(commit),
    .rdata_o(csr_rdata), .mtvec_o(mtvec), .mepc_o(mepc)
  );

  exu_branch u_branch (
    .ben_i(ben), .jen_i(jen), .ecall_i(ecall), .mret_i(mret),
    .alu_op_i(alu_op), .alu_res_i(alu_res), .target_i(target),
    .mtvec_i(mtvec), .mepc_i(mepc), .csr_rdata_i(csr_rdata),
    .src1_i(src1), .func3_i(func3),
    .redirect_o(branch_redirect), .npc_o(branch_npc), .csr_wdata_o(csr_wdata)
  );

  exu_dmem u_dmem (
    .clk(clk), .rst(rst),
    .req_i(mem_req), .we_i(mem_we), .addr_i(mem_addr), .wdata_i(mem_wdata),
    .ack_o(mem_ack), .rdata_o(mem_rdata)
  );

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module exu_tb
./obj_dir/Vexu_tb +verilator+error+limit+1000
